// ==== compile.f ====
logic/cpu_pkg.sv
logic/program_counter.sv
logic/instruction_memory.sv
logic/control_decoder.sv
logic/register_file.sv
logic/alu.sv
logic/data_memory.sv
logic/run_control.sv
logic/cpu_top.sv
dv/cpu_checker.sv
dv/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= tb_cpu
RTL_TOP   ?= cpu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int NUM_TESTS       = 5;
    localparam int MAX_PROG        = 20;              // Words per program
    localparam int MAX_PRE         = 6;               // Preloaded bytes per test
    localparam int MAX_RES         = 4;               // Result addresses per test
    localparam int HOLD_CYCLES     = 6;               // Start held high this long
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (MAX_CYCLES + 100);

    logic                clk;
    logic                reset;
    logic                start;
    logic                prog_we;
    logic [IMEM_AW-1:0]  prog_addr;
    logic [INSTR_W-1:0]  prog_data;
    logic                host_we;
    logic [DMEM_AW-1:0]  host_addr;
    logic [DATA_W-1:0]   host_wdata;
    logic [DATA_W-1:0]   host_rdata;
    logic                ack;
    logic [CYCLE_W-1:0]  cycle_count;
    logic                rd_check;                    // Tells checker to compare
    int                  err_count;
    int                  check_count;
    integer              seed;

    // Test table
    logic [INSTR_W-1:0]  prog_tab [NUM_TESTS][MAX_PROG];
    int                  prog_len [NUM_TESTS];
    logic [DMEM_AW-1:0]  pre_addr [NUM_TESTS][MAX_PRE];
    logic [DATA_W-1:0]   pre_val  [NUM_TESTS][MAX_PRE];
    int                  pre_n    [NUM_TESTS];
    logic [DMEM_AW-1:0]  res_addr [NUM_TESTS][MAX_RES];
    int                  res_n    [NUM_TESTS];

    cpu_top uut (
        .clk(clk), .reset(reset), .start(start),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata), .ack(ack), .cycle_count(cycle_count)
    );

    cpu_checker u_check (
        .clk(clk), .reset(reset), .start(start),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata), .ack(ack), .cycle_count(cycle_count),
        .rd_check(rd_check), .err_count(err_count), .check_count(check_count)
    );

    always #20 clk = ~clk;                            // 40 ns period

    function automatic logic [INSTR_W-1:0] reg_ins(opcode_e op, logic [1:0] ra, logic [1:0] rb);
        return {op, ra, rb, 2'b00};
    endfunction

    function automatic logic [INSTR_W-1:0] imm_ins(opcode_e op, logic [5:0] imm);
        return {op, imm};
    endfunction

    function automatic logic [DATA_W-1:0] rand_byte();
        return DATA_W'($random(seed));
    endfunction

    task automatic add_ins(input int t, input logic [INSTR_W-1:0] word);
        prog_tab[t][prog_len[t]] = word;
        prog_len[t]++;
    endtask

    task automatic add_pre(input int t, input logic [7:0] addr, input logic [7:0] val);
        pre_addr[t][pre_n[t]] = addr;
        pre_val[t][pre_n[t]]  = val;
        pre_n[t]++;
    endtask

    task automatic add_res(input int t, input logic [7:0] addr);
        res_addr[t][res_n[t]] = addr;
        res_n[t]++;
    endtask

    task automatic build_table;
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t] = 0;
            pre_n[t]    = 0;
            res_n[t]    = 0;
        end
        // 0: ADD, SUB, AND on random bytes, results at 32..34
        add_pre(0, 8'd16, rand_byte());
        add_pre(0, 8'd17, rand_byte());
        add_pre(0, 8'd20, 8'd32);                     // Store addresses
        add_pre(0, 8'd21, 8'd33);
        add_pre(0, 8'd22, 8'd34);
        add_ins(0, imm_ins(OP_LDI, 6'd20));
        add_ins(0, reg_ins(OP_LOAD, 2'd1, 2'd0));     // r0 = 32
        add_ins(0, imm_ins(OP_LDI, 6'd16));
        add_ins(0, reg_ins(OP_LOAD, 2'd1, 2'd2));     // r2 = A
        add_ins(0, imm_ins(OP_LDI, 6'd17));
        add_ins(0, reg_ins(OP_LOAD, 2'd1, 2'd3));     // r3 = B
        add_ins(0, reg_ins(OP_ADD, 2'd2, 2'd3));
        add_ins(0, reg_ins(OP_STORE, 2'd0, 2'd1));
        add_ins(0, imm_ins(OP_LDI, 6'd21));
        add_ins(0, reg_ins(OP_LOAD, 2'd1, 2'd0));
        add_ins(0, reg_ins(OP_SUB, 2'd2, 2'd3));
        add_ins(0, reg_ins(OP_STORE, 2'd0, 2'd1));
        add_ins(0, imm_ins(OP_LDI, 6'd22));
        add_ins(0, reg_ins(OP_LOAD, 2'd1, 2'd0));
        add_ins(0, reg_ins(OP_AND, 2'd2, 2'd3));
        add_ins(0, reg_ins(OP_STORE, 2'd0, 2'd1));
        add_ins(0, imm_ins(OP_HALT, 6'd0));
        add_res(0, 8'd32);
        add_res(0, 8'd33);
        add_res(0, 8'd34);
        // 1: LDI value moved to far addresses 200 and 255
        add_pre(1, 8'd5, 8'd200);
        add_pre(1, 8'd6, 8'd255);
        add_pre(1, 8'd200, rand_byte());              // Overwritten by the run
        add_ins(1, imm_ins(OP_LDI, 6'd5));
        add_ins(1, reg_ins(OP_LOAD, 2'd1, 2'd0));     // r0 = 200
        add_ins(1, imm_ins(OP_LDI, 6'd63));
        add_ins(1, reg_ins(OP_STORE, 2'd0, 2'd1));
        add_ins(1, reg_ins(OP_LOAD, 2'd0, 2'd2));     // r2 = mem[200]
        add_ins(1, imm_ins(OP_LDI, 6'd6));
        add_ins(1, reg_ins(OP_LOAD, 2'd1, 2'd3));     // r3 = 255
        add_ins(1, reg_ins(OP_STORE, 2'd3, 2'd2));
        add_ins(1, imm_ins(OP_HALT, 6'd0));
        add_res(1, 8'd200);
        add_res(1, 8'd255);
        // 2: countdown loop, forward exit and backward branch
        add_pre(2, 8'd41, 8'd40);
        add_pre(2, 8'd8, (rand_byte() % 8'd6) + 8'd1);
        add_pre(2, 8'd9, 8'd1);
        add_ins(2, imm_ins(OP_LDI, 6'd41));
        add_ins(2, reg_ins(OP_LOAD, 2'd1, 2'd0));     // r0 = 40
        add_ins(2, imm_ins(OP_LDI, 6'd8));
        add_ins(2, reg_ins(OP_LOAD, 2'd1, 2'd3));     // r3 = n
        add_ins(2, imm_ins(OP_LDI, 6'd9));
        add_ins(2, reg_ins(OP_LOAD, 2'd1, 2'd2));     // r2 = 1
        add_ins(2, reg_ins(OP_SUB, 2'd3, 2'd2));      // Loop head at 6
        add_ins(2, reg_ins(OP_STORE, 2'd0, 2'd1));
        add_ins(2, reg_ins(OP_LOAD, 2'd0, 2'd3));
        add_ins(2, imm_ins(OP_BZ, 6'd3));             // Exit to 12 on zero
        add_ins(2, imm_ins(OP_LDI, 6'd0));
        add_ins(2, imm_ins(OP_BZ, 6'd59));            // -5, back to 6
        add_ins(2, imm_ins(OP_HALT, 6'd0));
        add_res(2, 8'd40);
        add_res(2, 8'd8);
        // 3: branch to self forever, budget ends it
        add_pre(3, 8'd50, rand_byte());
        add_ins(3, imm_ins(OP_LDI, 6'd0));
        add_ins(3, imm_ins(OP_BZ, 6'd0));
        add_res(3, 8'd50);
        // 4: lone HALT
        add_pre(4, 8'd60, rand_byte());
        add_ins(4, imm_ins(OP_HALT, 6'd0));
        add_res(4, 8'd60);
    endtask

    task automatic read_results(input int t);
        for (int i = 0; i < res_n[t]; i++) begin
            @(posedge clk);
            host_addr <= res_addr[t][i];
            rd_check  <= 1'b1;
        end
        @(posedge clk);
        rd_check <= 1'b0;
    endtask

    task automatic run_test(input int t);
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < prog_len[t]; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= IMEM_AW'(i);
            prog_data <= prog_tab[t][i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        for (int i = 0; i < pre_n[t]; i++) begin
            @(posedge clk);
            host_we    <= 1'b1;
            host_addr  <= pre_addr[t][i];
            host_wdata <= pre_val[t][i];
        end
        @(posedge clk);
        host_we <= 1'b0;
        start   <= 1'b1;
        // Nothing may change while start stays high
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(posedge clk);
            host_addr <= res_addr[t][i % res_n[t]];
            rd_check  <= 1'b1;
        end
        @(posedge clk);
        start    <= 1'b0;
        rd_check <= 1'b0;
        while (ack !== 1'b1) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);                    // Memory must stay put after ack
        read_results(t);
        $display("Test %0d done, cycle_count %0d", t, cycle_count);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        start      = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        rd_check   = 1'b0;
        seed       = 32'h0093_c89f;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        repeat (2) @(posedge clk);
        $display("Checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0 && check_count > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, ack never arrived", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== dv/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         prog_we,     // Observed program strobe
    input  logic [cpu_pkg::IMEM_AW-1:0]  prog_addr,
    input  logic [cpu_pkg::INSTR_W-1:0]  prog_data,
    input  logic                         host_we,     // Observed preload strobe
    input  logic [cpu_pkg::DMEM_AW-1:0]  host_addr,
    input  logic [cpu_pkg::DATA_W-1:0]   host_wdata,
    input  logic [cpu_pkg::DATA_W-1:0]   host_rdata,
    input  logic                         ack,
    input  logic [cpu_pkg::CYCLE_W-1:0]  cycle_count,
    input  logic                         rd_check,    // Compare read-back this cycle
    output int                           err_count,
    output int                           check_count
);
    import cpu_pkg::*;

    logic [INSTR_W-1:0] m_imem [IMEM_DEPTH];          // Shadow program store
    logic [DATA_W-1:0]  m_dmem [2**DMEM_AW];          // Shadow data store
    logic [DATA_W-1:0]  m_regs [2**REG_AW];
    logic               seen;                         // Start sampled high
    logic               ran;                          // Model already executed
    logic               ack_q;                        // Ack at previous check
    int                 exp_count;

    initial begin
        err_count   = 0;
        check_count = 0;
        exp_count   = 0;
        ack_q       = 1'b0;
    end

    task automatic report(input string msg);
        $display("ERR %0t: %s", $time, msg);
        err_count++;
    endtask

    // ISA rules, one instruction per step, until HALT or budget
    task automatic run_model;
        logic [IMEM_AW-1:0] pc_m;
        logic [IMEM_AW-1:0] npc;
        logic [INSTR_W-1:0] ins;
        logic [2:0]         op;
        logic [1:0]         a;
        logic [1:0]         b;
        logic [5:0]         imm;
        int                 steps;
        bit                 halted;
        pc_m   = '0;
        steps  = 0;
        halted = 1'b0;
        while (!halted && steps < MAX_CYCLES) begin
            ins   = m_imem[pc_m];
            op    = ins[8:6];
            a     = ins[5:4];
            b     = ins[3:2];
            imm   = ins[5:0];
            npc   = pc_m + 6'd1;                      // Wraps at 64
            steps = steps + 1;
            case (op)
                3'd0: m_regs[1] = m_regs[a] + m_regs[b];
                3'd1: m_regs[1] = m_regs[a] - m_regs[b];
                3'd2: m_regs[1] = m_regs[a] & m_regs[b];
                3'd3: m_regs[b] = m_dmem[m_regs[a]];
                3'd4: m_dmem[m_regs[a]] = m_regs[b];
                3'd5: m_regs[1] = {2'b00, imm};       // Zero extended
                3'd6: begin
                    if (m_regs[1] == 8'd0) begin
                        npc = pc_m + imm;             // 6-bit add is the signed offset
                    end
                end
                default: halted = 1'b1;
            endcase
            pc_m = npc;
        end
        exp_count = steps;
    endtask

    // Mirror host writes, run the model when start falls
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                m_regs[i] = '0;
            end
            seen = 1'b0;
            ran  = 1'b0;
        end else begin
            if (prog_we) begin
                m_imem[prog_addr] = prog_data;
            end
            if (host_we) begin
                m_dmem[host_addr] = host_wdata;
            end
            if (start) begin
                seen = 1'b1;
            end else if (seen && !ran) begin
                run_model();
                ran = 1'b1;
            end
        end
    end

    // Outputs are settled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            ack_q = 1'b0;
        end else begin
            if (ack_q && !ack) begin
                report("ack fell before reset");
            end
            if (ack && !ack_q) begin
                check_count++;
                if (!ran) begin
                    report("ack rose before execution started");
                end else if (cycle_count !== CYCLE_W'(exp_count)) begin
                    report($sformatf("cycle_count %0d, expected %0d", cycle_count, exp_count));
                end
            end
            if (rd_check) begin
                check_count++;
                if (host_rdata !== m_dmem[host_addr]) begin
                    report($sformatf("mem[%0d] = %h, expected %h",
                                     host_addr, host_rdata, m_dmem[host_addr]));
                end
            end
            ack_q = ack;
        end
    end

endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         prog_we,     // Program load strobe
    input  logic [cpu_pkg::IMEM_AW-1:0]  prog_addr,
    input  logic [cpu_pkg::INSTR_W-1:0]  prog_data,
    input  logic                         host_we,     // Data preload strobe
    input  logic [cpu_pkg::DMEM_AW-1:0]  host_addr,   // Preload and read-back
    input  logic [cpu_pkg::DATA_W-1:0]   host_wdata,
    output logic [cpu_pkg::DATA_W-1:0]   host_rdata,
    output logic                         ack,
    output logic [cpu_pkg::CYCLE_W-1:0]  cycle_count
);
    import cpu_pkg::*;

    // Sequencing
    logic               running;
    logic               halt;
    logic [IMEM_AW-1:0] pc;
    instr_u             instr;

    // Decoded controls
    opcode_e            alu_op;
    logic               reg_we;
    logic               dest_is_rb;
    logic               mem_read;
    logic               mem_write;
    logic               use_imm;
    logic               branch_en;
    logic [REG_AW-1:0]  ra;
    logic [REG_AW-1:0]  rb;
    logic [IMM_W-1:0]   imm6;

    // Datapath
    logic [REG_AW-1:0]  waddr;
    logic [DATA_W-1:0]  wb_data;
    logic [DATA_W-1:0]  data_a;
    logic [DATA_W-1:0]  data_b;
    logic [DATA_W-1:0]  data_r1;
    logic [DATA_W-1:0]  alu_a;
    logic [DATA_W-1:0]  alu_b;
    logic [DATA_W-1:0]  alu_result;
    logic               zero;
    logic [DATA_W-1:0]  mem_rdata;

    run_control u_run (
        .clk(clk), .reset(reset), .start(start), .halt(halt),
        .running(running), .ack(ack), .cycle_count(cycle_count)
    );

    program_counter u_pc (
        .clk(clk), .reset(reset), .running(running), .branch_en(branch_en),
        .zero(zero), .imm6(imm6), .pc(pc)
    );

    instruction_memory u_imem (
        .clk(clk), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .pc(pc), .instr(instr)
    );

    control_decoder u_dec (
        .running(running), .instr(instr), .alu_op(alu_op), .reg_we(reg_we),
        .dest_is_rb(dest_is_rb), .mem_read(mem_read), .mem_write(mem_write),
        .use_imm(use_imm), .branch_en(branch_en), .halt(halt),
        .ra(ra), .rb(rb), .imm6(imm6)
    );

    // Destination is r1 unless LOAD
    assign waddr = dest_is_rb ? rb : REG_AW'(1);

    register_file u_rf (
        .clk(clk), .reset(reset), .ra(ra), .rb(rb), .we(reg_we),
        .waddr(waddr), .wdata(wb_data),
        .data_a(data_a), .data_b(data_b), .data_r1(data_r1)
    );

    // Operand select: branch test, immediate, or register pair
    always_comb begin
        if (branch_en) begin
            alu_a = data_r1;                          // Zero flag tests r1
            alu_b = '0;
        end else if (use_imm) begin
            alu_a = '0;
            alu_b = {{(DATA_W-IMM_W){1'b0}}, imm6};  // Zero-extended immediate
        end else begin
            alu_a = data_a;
            alu_b = data_b;
        end
    end

    alu u_alu (
        .a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result), .zero(zero)
    );

    // ra holds the address, rb the store data
    data_memory u_dmem (
        .clk(clk), .mem_write(mem_write), .addr(data_a), .wdata(data_b),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .rdata(mem_rdata), .host_rdata(host_rdata)
    );

    assign wb_data = mem_read ? mem_rdata : alu_result;  // LOAD takes memory byte

endmodule

// ==== logic/run_control.sv ====
`timescale 1ns/1ps

module run_control (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,       // Host raises then lowers
    input  logic                         halt,        // HALT executing
    output logic                         running,
    output logic                         ack,         // Sticky until reset
    output logic [cpu_pkg::CYCLE_W-1:0]  cycle_count
);
    import cpu_pkg::*;

    logic start_seen;                                 // Start was sampled high
    logic budget_hit;                                 // Last allowed cycle
    logic stop;

    // Count reaches MAX_CYCLES at the end of this cycle
    assign budget_hit = (cycle_count == CYCLE_W'(MAX_CYCLES - 1));
    assign stop       = running && (halt || budget_hit);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_seen  <= 1'b0;
            running     <= 1'b0;
            ack         <= 1'b0;
            cycle_count <= '0;
        end else begin
            if (start) begin
                start_seen <= 1'b1;
            end
            if (running) begin
                cycle_count <= cycle_count + 1'b1;    // HALT cycle counted too
                if (stop) begin
                    running <= 1'b0;                  // Count freezes here
                    ack     <= 1'b1;
                end
            end else if (start_seen && !start && !ack) begin
                running <= 1'b1;                      // Falling edge of start
            end
        end
    end

endmodule

// ==== logic/data_memory.sv ====
`timescale 1ns/1ps

module data_memory (
    input  logic                         clk,
    input  logic                         mem_write,   // STORE from core
    input  logic [cpu_pkg::DMEM_AW-1:0]  addr,        // Core address, from ra
    input  logic [cpu_pkg::DATA_W-1:0]   wdata,       // Core data, from rb
    input  logic                         host_we,     // Host preload strobe
    input  logic [cpu_pkg::DMEM_AW-1:0]  host_addr,
    input  logic [cpu_pkg::DATA_W-1:0]   host_wdata,
    output logic [cpu_pkg::DATA_W-1:0]   rdata,       // Core read, for LOAD
    output logic [cpu_pkg::DATA_W-1:0]   host_rdata   // Host read-back
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] mem [2**DMEM_AW];              // No reset, contents persist

    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        if (mem_write) begin
            mem[addr] <= wdata;                       // Core wins on collision
        end
    end

    // Both reads are asynchronous
    assign rdata      = mem[addr];
    assign host_rdata = mem[host_addr];

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::DATA_W-1:0]   a,
    input  logic [cpu_pkg::DATA_W-1:0]   b,
    input  cpu_pkg::opcode_e             op,
    output logic [cpu_pkg::DATA_W-1:0]   result,
    output logic                         zero         // Result is all zeros
);
    import cpu_pkg::*;

    always_comb begin
        case (op)
            OP_ADD:  result = a + b;                  // Modulo 256, carry dropped
            OP_SUB:  result = a - b;                  // Modulo 256, borrow dropped
            OP_AND:  result = a & b;
            OP_BZ:   result = a;                      // Pass r1 for the zero test
            default: result = b;                      // Pass b, covers LDI
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [cpu_pkg::REG_AW-1:0]   ra,          // Read port A
    input  logic [cpu_pkg::REG_AW-1:0]   rb,          // Read port B
    input  logic                         we,
    input  logic [cpu_pkg::REG_AW-1:0]   waddr,
    input  logic [cpu_pkg::DATA_W-1:0]   wdata,
    output logic [cpu_pkg::DATA_W-1:0]   data_a,
    output logic [cpu_pkg::DATA_W-1:0]   data_b,
    output logic [cpu_pkg::DATA_W-1:0]   data_r1      // Accumulator, for BZ
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] regs [2**REG_AW];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;                        // All registers start at zero
            end
        end else if (we) begin
            regs[waddr] <= wdata;                     // Visible next cycle
        end
    end

    assign data_a  = regs[ra];
    assign data_b  = regs[rb];
    assign data_r1 = regs[1];                         // Fixed r1 read

endmodule

// ==== logic/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder (
    input  logic                         running,     // Gates all enables
    input  cpu_pkg::instr_u              instr,
    output cpu_pkg::opcode_e             alu_op,
    output logic                         reg_we,      // Register write
    output logic                         dest_is_rb,  // LOAD writes rb, else r1
    output logic                         mem_read,    // Write back memory data
    output logic                         mem_write,   // STORE strobe
    output logic                         use_imm,     // LDI operand select
    output logic                         branch_en,   // BZ in execute
    output logic                         halt,
    output logic [cpu_pkg::REG_AW-1:0]   ra,
    output logic [cpu_pkg::REG_AW-1:0]   rb,
    output logic [cpu_pkg::IMM_W-1:0]    imm6
);
    import cpu_pkg::*;

    opcode_e opcode;

    // Both layouts share the opcode bits
    assign opcode = instr.reg_form.opcode;
    assign ra     = instr.reg_form.ra;
    assign rb     = instr.reg_form.rb;
    assign imm6   = instr.imm_form.imm6;

    always_comb begin
        alu_op     = opcode;                          // ALU follows opcode by default
        reg_we     = 1'b0;
        dest_is_rb = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        use_imm    = 1'b0;
        branch_en  = 1'b0;
        halt       = 1'b0;
        unique case (opcode)
            OP_ADD, OP_SUB, OP_AND: begin
                reg_we = running;                     // Result into r1
            end
            OP_LOAD: begin
                reg_we     = running;
                dest_is_rb = 1'b1;                    // rb = mem[ra]
                mem_read   = running;
            end
            OP_STORE: begin
                mem_write = running;                  // mem[ra] = rb
            end
            OP_LDI: begin
                reg_we  = running;
                use_imm = 1'b1;                       // 0 + zext(imm6)
            end
            OP_BZ: begin
                branch_en = running;                  // ALU passes r1 for zero test
            end
            OP_HALT: begin
                halt = running;
            end
        endcase
    end

endmodule

// ==== logic/instruction_memory.sv ====
`timescale 1ns/1ps

module instruction_memory (
    input  logic                         clk,
    input  logic                         prog_we,     // Host load strobe
    input  logic [cpu_pkg::IMEM_AW-1:0]  prog_addr,
    input  logic [cpu_pkg::INSTR_W-1:0]  prog_data,
    input  logic [cpu_pkg::IMEM_AW-1:0]  pc,          // Fetch address
    output cpu_pkg::instr_u              instr        // Fetched word
);
    import cpu_pkg::*;

    logic [INSTR_W-1:0] mem [IMEM_DEPTH];             // Program store, survives reset

    // Host writes only while the core is idle
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    assign instr = mem[pc];                           // Combinational fetch

endmodule

// ==== logic/program_counter.sv ====
`timescale 1ns/1ps

module program_counter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         running,     // One instruction per cycle
    input  logic                         branch_en,   // BZ in execute
    input  logic                         zero,        // r1 == 0 from ALU
    input  logic [cpu_pkg::IMM_W-1:0]    imm6,        // Signed branch offset
    output logic [cpu_pkg::IMEM_AW-1:0]  pc
);
    import cpu_pkg::*;

    logic [IMEM_AW-1:0] offset;                       // Sign-extended imm6
    logic [IMEM_AW-1:0] pc_seq;                       // Fall-through target
    logic [IMEM_AW-1:0] pc_br;                        // Taken-branch target
    logic               take_branch;

    assign offset      = IMEM_AW'(signed'(imm6));     // Sign extend to PC width
    assign pc_seq      = pc + 1'b1;                   // Wraps modulo 64
    assign pc_br       = pc + offset;                 // Backward when imm6 negative
    assign take_branch = branch_en && zero;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;                                 // Programs start at word 0
        end else if (running) begin
            pc <= take_branch ? pc_br : pc_seq;
        end
    end

endmodule

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    // Word and array sizes
    localparam int INSTR_W    = 9;              // Instruction word width
    localparam int DATA_W     = 8;              // Register and memory byte width
    localparam int IMM_W      = 6;              // Immediate field width
    localparam int IMEM_DEPTH = 64;             // Program words
    localparam int IMEM_AW    = 6;              // Program address width
    localparam int DMEM_AW    = 8;              // 256 data bytes
    localparam int REG_AW     = 2;              // Four registers

    // Run limits
    localparam int MAX_CYCLES = 200;            // Budget before forced ack
    localparam int CYCLE_W    = 16;             // Executed-cycle counter width

    // Primary opcodes, top three bits of every instruction
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,                        // r1 = ra + rb
        OP_SUB   = 3'd1,                        // r1 = ra - rb
        OP_AND   = 3'd2,                        // r1 = ra & rb
        OP_LOAD  = 3'd3,                        // rb = mem[ra]
        OP_STORE = 3'd4,                        // mem[ra] = rb
        OP_LDI   = 3'd5,                        // r1 = zext(imm6)
        OP_BZ    = 3'd6,                        // Branch if r1 == 0
        OP_HALT  = 3'd7                         // Stop execution
    } opcode_e;

    // Same 9-bit word, two field layouts selected by opcode
    typedef union packed {
        struct packed {
            opcode_e             opcode;        // Shared opcode position
            logic [REG_AW-1:0]   ra;            // Address / first operand reg
            logic [REG_AW-1:0]   rb;            // Data / second operand reg
            logic [1:0]          spare;         // Unused low bits
        } reg_form;
        struct packed {
            opcode_e             opcode;        // Shared opcode position
            logic [IMM_W-1:0]    imm6;          // LDI value or BZ offset
        } imm_form;
    } instr_u;

endpackage
